/* verilog.f */
logic/lane_ctrl_pkg.sv
logic/vrf_addr_counter.sv
logic/byte_write_enable_gen.sv
logic/lane_valid_tracker.sv
logic/sublane_sequencer.sv
logic/partial_sublane_driver.sv
tests/tb_partial_sublane_driver.sv

/* Bender.yml */
package:
  name: partial_sublane_driver

sources:
  - logic/lane_ctrl_pkg.sv
  - logic/vrf_addr_counter.sv
  - logic/byte_write_enable_gen.sv
  - logic/lane_valid_tracker.sv
  - logic/sublane_sequencer.sv
  - logic/partial_sublane_driver.sv
  - target: simulation
    files:
      - tests/tb_partial_sublane_driver.sv

/* tests/tb_partial_sublane_driver.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_partial_sublane_driver;

    localparam int VLANE_NUM       = 8;
    localparam int MAX_VL_PER_LANE = 256;
    localparam int MEM_DEPTH       = 512;
    localparam int VL_W            = $clog2(VLANE_NUM * MAX_VL_PER_LANE);
    localparam int DLY_W           = $clog2(MAX_VL_PER_LANE);
    localparam int ADDR_W          = $clog2(MEM_DEPTH);
    localparam int BWEN_W          = VLANE_NUM * lane_ctrl_pkg::BYTES_PER_WORD;
    localparam int NUM_INST        = 36;
    localparam int READY_TIMEOUT   = 200;   // Cycles well above 2L plus delay

    logic                       clk_i;
    logic                       rst_i;
    logic                       start_i;
    lane_ctrl_pkg::inst_type_e  inst_type_i;
    logic [VL_W-1:0]            vl_i;
    lane_ctrl_pkg::elem_width_e vsew_i;
    lane_ctrl_pkg::write_sew_e  vrf_write_sew_i;
    logic [DLY_W-1:0]           inst_delay_i;
    logic                       vector_mask_i;
    logic [ADDR_W-1:0]          vrf_starting_waddr_i;
    logic [ADDR_W-1:0]          vrf_starting_raddr0_i;
    logic [ADDR_W-1:0]          vrf_starting_raddr1_i;
    logic [ADDR_W-1:0]          vrf_starting_raddr2_i;
    logic                       ready_o;
    logic [ADDR_W-1:0]          vrf_waddr_o;
    logic [ADDR_W-1:0]          vrf_raddr0_o;
    logic [ADDR_W-1:0]          vrf_raddr1_o;
    logic [ADDR_W-1:0]          vrf_raddr2_o;
    logic [BWEN_W-1:0]          vrf_bwen_o;
    logic [DLY_W-1:0]           vmrf_addr_o;
    logic                       vmrf_wen_o;
    logic [VLANE_NUM-1:0]       read_data_valid_o;
    logic                       store_data_valid_o;
    logic                       store_load_index_valid_o;

    logic [31:0]                lfsr_q;

    // Instruction under check as latched on the accept edge
    lane_ctrl_pkg::inst_type_e  cur_type;
    lane_ctrl_pkg::elem_width_e cur_vsew;
    lane_ctrl_pkg::write_sew_e  cur_wsew;
    logic [VL_W-1:0]            cur_vl;
    logic [DLY_W-1:0]           cur_delay;
    logic                       cur_mask;
    logic [ADDR_W-1:0]          cur_waddr;
    logic [ADDR_W-1:0]          cur_raddr0;
    logic [ADDR_W-1:0]          cur_raddr1;
    logic [ADDR_W-1:0]          cur_raddr2;

    partial_sublane_driver #(
        .VLANE_NUM(VLANE_NUM),
        .MAX_VL_PER_LANE(MAX_VL_PER_LANE),
        .MEM_DEPTH(MEM_DEPTH)
    ) u_dut (
        .clk_i(clk_i),
        .rst_i(rst_i),
        .start_i(start_i),
        .inst_type_i(inst_type_i),
        .vl_i(vl_i),
        .vsew_i(vsew_i),
        .vrf_write_sew_i(vrf_write_sew_i),
        .inst_delay_i(inst_delay_i),
        .vector_mask_i(vector_mask_i),
        .vrf_starting_waddr_i(vrf_starting_waddr_i),
        .vrf_starting_raddr0_i(vrf_starting_raddr0_i),
        .vrf_starting_raddr1_i(vrf_starting_raddr1_i),
        .vrf_starting_raddr2_i(vrf_starting_raddr2_i),
        .ready_o(ready_o),
        .vrf_waddr_o(vrf_waddr_o),
        .vrf_raddr0_o(vrf_raddr0_o),
        .vrf_raddr1_o(vrf_raddr1_o),
        .vrf_raddr2_o(vrf_raddr2_o),
        .vrf_bwen_o(vrf_bwen_o),
        .vmrf_addr_o(vmrf_addr_o),
        .vmrf_wen_o(vmrf_wen_o),
        .read_data_valid_o(read_data_valid_o),
        .store_data_valid_o(store_data_valid_o),
        .store_load_index_valid_o(store_load_index_valid_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    //////////////////////////////
    // Random source
    //////////////////////////////
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);   // x^32+x^22+x^2+x+1
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int b = 0; b < n; b++) begin
            val    = {val[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    //////////////////////////////
    // Reference model
    //////////////////////////////
    function automatic int elems_per_word(input lane_ctrl_pkg::elem_width_e w);
        case (w)
            lane_ctrl_pkg::EW_BYTE: return 4;
            lane_ctrl_pkg::EW_HALF: return 2;
            default:                return 1;
        endcase
    endfunction

    // t counts clock edges since the accept edge
    function automatic void expected_outputs(
        input  int                   t,
        input  logic                 busy,
        output int                   phase,
        output logic                 ready,
        output logic                 sdv,
        output logic                 liv,
        output logic [VLANE_NUM-1:0] rdv,
        output logic [BWEN_W-1:0]    bwen,
        output logic                 vwen,
        output logic [DLY_W-1:0]     vaddr,
        output logic [ADDR_W-1:0]    waddr,
        output logic [ADDR_W-1:0]    raddr0,
        output logic [ADDR_W-1:0]    raddr1,
        output logic [ADDR_W-1:0]    raddr2
    );
        int         len;
        int         per_r;
        int         per_w;
        int         k;
        int         m;
        int         last_t;
        logic [3:0] pat;
        phase  = 0;
        ready  = 1'b1;
        sdv    = 1'b0;
        liv    = 1'b0;
        rdv    = '0;
        bwen   = '0;
        vwen   = 1'b0;
        vaddr  = '0;
        waddr  = '0;
        raddr0 = '0;
        raddr1 = '0;
        raddr2 = '0;
        if (busy) begin
            len    = (int'(cur_vl) + VLANE_NUM - 1) / VLANE_NUM;
            per_r  = (cur_type == lane_ctrl_pkg::STORE) ? 1 : elems_per_word(cur_vsew);
            per_w  = (cur_wsew == lane_ctrl_pkg::WS_BYTE) ? 4 :
                     (cur_wsew == lane_ctrl_pkg::WS_HALF) ? 2 : 1;
            last_t = (cur_type == lane_ctrl_pkg::NORMAL) ? 2 * len + int'(cur_delay) : len;
            ready  = (t > last_t);
            if (t >= 1 && t <= len) begin
                k      = t - 1;     // Read group index
                phase  = 1;
                sdv    = (cur_type == lane_ctrl_pkg::STORE)
                      || (cur_type == lane_ctrl_pkg::INDEXED_STORE);
                liv    = (cur_type == lane_ctrl_pkg::INDEXED_STORE)
                      || (cur_type == lane_ctrl_pkg::INDEXED_LOAD);
                for (int j = 0; j < VLANE_NUM; j++) begin
                    rdv[j] = (k * VLANE_NUM + j < int'(cur_vl));
                end
                raddr0 = cur_raddr0 + ADDR_W'(k / per_r);
                raddr1 = cur_raddr1 + ADDR_W'(k / per_r);
                raddr2 = cur_raddr2 + ADDR_W'(k / per_r);
            end else if (cur_type == lane_ctrl_pkg::NORMAL
                         && t > len + int'(cur_delay) && t <= last_t) begin
                m     = t - len - 1 - int'(cur_delay);
                phase = 2;
                vwen  = cur_mask;
                vaddr = DLY_W'(m);
                waddr = cur_waddr + ADDR_W'(m / per_w);
                case (per_w)
                    4:       pat = 4'b0001 << (m % 4);
                    2:       pat = (m % 2 == 0) ? 4'b0011 : 4'b1100;
                    default: pat = 4'b1111;
                endcase
                bwen = {VLANE_NUM{pat}};
            end
        end
    endfunction

    //////////////////////////////
    // Checking
    //////////////////////////////
    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    initial begin : compare
        int                   t;
        logic                 busy;
        logic                 prev_ready;
        int                   phase;
        logic                 e_ready;
        logic                 e_sdv;
        logic                 e_liv;
        logic [VLANE_NUM-1:0] e_rdv;
        logic [BWEN_W-1:0]    e_bwen;
        logic                 e_vwen;
        logic [DLY_W-1:0]     e_vaddr;
        logic [ADDR_W-1:0]    e_waddr;
        logic [ADDR_W-1:0]    e_raddr0;
        logic [ADDR_W-1:0]    e_raddr1;
        logic [ADDR_W-1:0]    e_raddr2;
        t          = 0;
        busy       = 1'b0;
        prev_ready = 1'b0;
        forever begin
            @(posedge clk_i);
            #1;                 // Outputs settled and inputs still held
            if (rst_i) begin
                if (start_i && prev_ready) begin
                    cur_type   = inst_type_i;
                    cur_vsew   = vsew_i;
                    cur_wsew   = vrf_write_sew_i;
                    cur_vl     = vl_i;
                    cur_delay  = inst_delay_i;
                    cur_mask   = vector_mask_i;
                    cur_waddr  = vrf_starting_waddr_i;
                    cur_raddr0 = vrf_starting_raddr0_i;
                    cur_raddr1 = vrf_starting_raddr1_i;
                    cur_raddr2 = vrf_starting_raddr2_i;
                    busy       = 1'b1;
                    t          = 0;
                end else if (busy) begin
                    t++;
                end
                expected_outputs(t, busy, phase, e_ready, e_sdv, e_liv, e_rdv, e_bwen,
                                 e_vwen, e_vaddr, e_waddr, e_raddr0, e_raddr1, e_raddr2);
                check_value("ready_o", ready_o, e_ready);
                check_value("store_data_valid_o", store_data_valid_o, e_sdv);
                check_value("store_load_index_valid_o", store_load_index_valid_o, e_liv);
                check_value("read_data_valid_o", read_data_valid_o, e_rdv);
                check_value("vrf_bwen_o", vrf_bwen_o, e_bwen);
                check_value("vmrf_wen_o", vmrf_wen_o, e_vwen);
                if (phase == 1) begin
                    check_value("vrf_raddr0_o", vrf_raddr0_o, e_raddr0);
                    check_value("vrf_raddr1_o", vrf_raddr1_o, e_raddr1);
                    check_value("vrf_raddr2_o", vrf_raddr2_o, e_raddr2);
                end
                if (phase == 2) begin
                    check_value("vrf_waddr_o", vrf_waddr_o, e_waddr);
                    check_value("vmrf_addr_o", vmrf_addr_o, e_vaddr);
                end
                if (busy && e_ready) begin
                    busy = 1'b0;    // Back in idle
                end
            end
            prev_ready = ready_o;
        end
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////
    task automatic wait_ready();
        int n;
        n = 0;
        while (!ready_o && n < READY_TIMEOUT) begin
            @(negedge clk_i);
            n++;
        end
        if (!ready_o) begin
            $display("Timeout: ready_o stayed low for %0d cycles", READY_TIMEOUT);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    // Junk on the fields once the instruction is captured
    task automatic scramble_fields();
        logic [31:0] r;
        inst_type_i = lane_ctrl_pkg::SLIDE;
        if (vsew_i == lane_ctrl_pkg::EW_BYTE) begin
            vsew_i = lane_ctrl_pkg::EW_WORD;
        end else begin
            vsew_i = lane_ctrl_pkg::EW_BYTE;
        end
        if (vrf_write_sew_i == lane_ctrl_pkg::WS_BYTE) begin
            vrf_write_sew_i = lane_ctrl_pkg::WS_WORD;
        end else begin
            vrf_write_sew_i = lane_ctrl_pkg::WS_BYTE;
        end
        draw_bits(VL_W, r);
        vl_i = VL_W'(r);
        draw_bits(DLY_W, r);
        inst_delay_i = DLY_W'(r);
        vector_mask_i = ~vector_mask_i;
        draw_bits(ADDR_W, r);
        vrf_starting_waddr_i  = ADDR_W'(r);
        vrf_starting_raddr0_i = ~vrf_starting_raddr0_i;
        vrf_starting_raddr1_i = ~vrf_starting_raddr1_i;
        vrf_starting_raddr2_i = ~vrf_starting_raddr2_i;
    endtask

    // Called on a falling edge with ready_o high
    task automatic issue_instruction(input int idx);
        logic [31:0] r;
        case (idx % 4)
            0:       inst_type_i = lane_ctrl_pkg::NORMAL;
            1:       inst_type_i = lane_ctrl_pkg::STORE;
            2:       inst_type_i = lane_ctrl_pkg::INDEXED_STORE;
            default: inst_type_i = lane_ctrl_pkg::INDEXED_LOAD;
        endcase
        vsew_i          = lane_ctrl_pkg::elem_width_e'((idx / 4) % 3);
        vrf_write_sew_i = lane_ctrl_pkg::write_sew_e'((idx / 4) % 3 + 1);
        draw_bits(7, r);
        vl_i = VL_W'(r + 1);    // 1 to 128 elements
        draw_bits(3, r);
        inst_delay_i = DLY_W'(r);
        draw_bits(1, r);
        vector_mask_i = r[0];
        draw_bits(ADDR_W, r);
        vrf_starting_waddr_i = ADDR_W'(r);
        draw_bits(ADDR_W, r);
        vrf_starting_raddr0_i = ADDR_W'(r);
        draw_bits(ADDR_W, r);
        vrf_starting_raddr1_i = ADDR_W'(r);
        draw_bits(ADDR_W, r);
        vrf_starting_raddr2_i = ADDR_W'(r);
        start_i = 1'b1;
        @(negedge clk_i);
        start_i = 1'b0;
        scramble_fields();
    endtask

    initial begin : stimulus
        logic [31:0] gap;
        lfsr_q                = 32'h1bdf_a669;
        rst_i                 = 1'b0;
        start_i               = 1'b0;
        inst_type_i           = lane_ctrl_pkg::NORMAL;
        vl_i                  = '0;
        vsew_i                = lane_ctrl_pkg::EW_BYTE;
        vrf_write_sew_i       = lane_ctrl_pkg::WS_BYTE;
        inst_delay_i          = '0;
        vector_mask_i         = 1'b0;
        vrf_starting_waddr_i  = '0;
        vrf_starting_raddr0_i = '0;
        vrf_starting_raddr1_i = '0;
        vrf_starting_raddr2_i = '0;
        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b1;
        repeat (3) @(negedge clk_i);    // Idle outputs get checked here
        for (int i = 0; i < NUM_INST; i++) begin
            wait_ready();
            draw_bits(2, gap);
            repeat (gap[1:0]) @(negedge clk_i);     // Zero means back to back
            issue_instruction(i);
        end
        wait_ready();
        repeat (2) @(negedge clk_i);
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* logic/partial_sublane_driver.sv */
`timescale 1ns/1ps
`default_nettype none

module partial_sublane_driver #(
    parameter int  VLANE_NUM       = 8,
    parameter int  MAX_VL_PER_LANE = 256,
    parameter int  MEM_DEPTH       = 512,
    localparam int VL_W            = $clog2(VLANE_NUM * MAX_VL_PER_LANE),
    localparam int DLY_W           = $clog2(MAX_VL_PER_LANE),
    localparam int ADDR_W          = $clog2(MEM_DEPTH),
    localparam int BWEN_W          = VLANE_NUM * lane_ctrl_pkg::BYTES_PER_WORD
) (
    input  wire                             clk_i,
    input  wire                             rst_i,
    input  wire                             start_i,
    input  wire lane_ctrl_pkg::inst_type_e  inst_type_i,
    input  wire        [VL_W-1:0]           vl_i,
    input  wire lane_ctrl_pkg::elem_width_e vsew_i,
    input  wire lane_ctrl_pkg::write_sew_e  vrf_write_sew_i,
    input  wire        [DLY_W-1:0]          inst_delay_i,
    input  wire                             vector_mask_i,
    input  wire        [ADDR_W-1:0]         vrf_starting_waddr_i,
    input  wire        [ADDR_W-1:0]         vrf_starting_raddr0_i,
    input  wire        [ADDR_W-1:0]         vrf_starting_raddr1_i,
    input  wire        [ADDR_W-1:0]         vrf_starting_raddr2_i,
    output logic                            ready_o,
    output logic       [ADDR_W-1:0]         vrf_waddr_o,
    output logic       [ADDR_W-1:0]         vrf_raddr0_o,
    output logic       [ADDR_W-1:0]         vrf_raddr1_o,
    output logic       [ADDR_W-1:0]         vrf_raddr2_o,
    output logic       [BWEN_W-1:0]         vrf_bwen_o,
    output logic       [DLY_W-1:0]          vmrf_addr_o,
    output logic                            vmrf_wen_o,
    output logic       [VLANE_NUM-1:0]      read_data_valid_o,
    output logic                            store_data_valid_o,
    output logic                            store_load_index_valid_o
);

    logic                       addr_load;
    logic                       raddr_en;
    logic                       waddr_en;
    logic                       bwen_en;
    logic                       vl_load;
    logic                       vl_shift;
    lane_ctrl_pkg::elem_width_e rd_width;
    lane_ctrl_pkg::elem_width_e wr_width;
    logic [VL_W-1:0]            vl;
    logic [ADDR_W-1:0]          start_waddr;
    logic [ADDR_W-1:0]          start_raddr0;
    logic [ADDR_W-1:0]          start_raddr1;
    logic [ADDR_W-1:0]          start_raddr2;

    //////////////////////////////
    // Control
    //////////////////////////////
    sublane_sequencer #(
        .VLANE_NUM(VLANE_NUM),
        .MAX_VL_PER_LANE(MAX_VL_PER_LANE),
        .MEM_DEPTH(MEM_DEPTH)
    ) u_seq (
        .clk_i(clk_i),
        .rst_i(rst_i),
        .start_i(start_i),
        .inst_type_i(inst_type_i),
        .vl_i(vl_i),
        .vsew_i(vsew_i),
        .vrf_write_sew_i(vrf_write_sew_i),
        .inst_delay_i(inst_delay_i),
        .vector_mask_i(vector_mask_i),
        .vrf_starting_waddr_i(vrf_starting_waddr_i),
        .vrf_starting_raddr0_i(vrf_starting_raddr0_i),
        .vrf_starting_raddr1_i(vrf_starting_raddr1_i),
        .vrf_starting_raddr2_i(vrf_starting_raddr2_i),
        .ready_o(ready_o),
        .addr_load_o(addr_load),
        .raddr_en_o(raddr_en),
        .waddr_en_o(waddr_en),
        .rd_width_o(rd_width),
        .wr_width_o(wr_width),
        .bwen_en_o(bwen_en),
        .vl_load_o(vl_load),
        .vl_shift_o(vl_shift),
        .vmrf_addr_o(vmrf_addr_o),
        .vmrf_wen_o(vmrf_wen_o),
        .store_data_valid_o(store_data_valid_o),
        .store_load_index_valid_o(store_load_index_valid_o),
        .vl_o(vl),
        .start_waddr_o(start_waddr),
        .start_raddr0_o(start_raddr0),
        .start_raddr1_o(start_raddr1),
        .start_raddr2_o(start_raddr2)
    );

    //////////////////////////////
    // Address generation
    //////////////////////////////
    vrf_addr_counter #(
        .MEM_DEPTH(MEM_DEPTH)
    ) u_waddr_cnt (
        .clk_i(clk_i),
        .rst_i(rst_i),
        .load_i(addr_load),
        .start_addr_i(start_waddr),
        .en_i(waddr_en),
        .width_i(wr_width),
        .addr_o(vrf_waddr_o)
    );

    // Operand ports 0 to 2 share the same read stream
    vrf_addr_counter #(
        .MEM_DEPTH(MEM_DEPTH)
    ) u_raddr_cnt [2:0] (
        .clk_i(clk_i),
        .rst_i(rst_i),
        .load_i(addr_load),
        .start_addr_i({start_raddr2, start_raddr1, start_raddr0}),
        .en_i(raddr_en),
        .width_i(rd_width),
        .addr_o({vrf_raddr2_o, vrf_raddr1_o, vrf_raddr0_o})
    );

    byte_write_enable_gen #(
        .VLANE_NUM(VLANE_NUM)
    ) u_bwen_gen (
        .clk_i(clk_i),
        .rst_i(rst_i),
        .en_i(bwen_en),
        .width_i(wr_width),
        .bwen_o(vrf_bwen_o)
    );

    lane_valid_tracker #(
        .VLANE_NUM(VLANE_NUM),
        .MAX_VL_PER_LANE(MAX_VL_PER_LANE)
    ) u_valid_trk (
        .clk_i(clk_i),
        .rst_i(rst_i),
        .load_i(vl_load),
        .vl_i(vl),
        .shift_i(vl_shift),
        .valid_o(read_data_valid_o)
    );

endmodule

`default_nettype wire

/* logic/sublane_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module sublane_sequencer #(
    parameter int  VLANE_NUM       = 8,
    parameter int  MAX_VL_PER_LANE = 256,
    parameter int  MEM_DEPTH       = 512,
    localparam int VL_W            = $clog2(VLANE_NUM * MAX_VL_PER_LANE),
    localparam int DLY_W           = $clog2(MAX_VL_PER_LANE),
    localparam int ADDR_W          = $clog2(MEM_DEPTH)
) (
    input  wire                             clk_i,
    input  wire                             rst_i,
    input  wire                             start_i,
    input  wire lane_ctrl_pkg::inst_type_e  inst_type_i,
    input  wire        [VL_W-1:0]           vl_i,
    input  wire lane_ctrl_pkg::elem_width_e vsew_i,
    input  wire lane_ctrl_pkg::write_sew_e  vrf_write_sew_i,
    input  wire        [DLY_W-1:0]          inst_delay_i,
    input  wire                             vector_mask_i,
    input  wire        [ADDR_W-1:0]         vrf_starting_waddr_i,
    input  wire        [ADDR_W-1:0]         vrf_starting_raddr0_i,
    input  wire        [ADDR_W-1:0]         vrf_starting_raddr1_i,
    input  wire        [ADDR_W-1:0]         vrf_starting_raddr2_i,
    output logic                            ready_o,
    output logic                            addr_load_o,
    output logic                            raddr_en_o,
    output logic                            waddr_en_o,
    output lane_ctrl_pkg::elem_width_e      rd_width_o,
    output lane_ctrl_pkg::elem_width_e      wr_width_o,
    output logic                            bwen_en_o,
    output logic                            vl_load_o,
    output logic                            vl_shift_o,
    output logic       [DLY_W-1:0]          vmrf_addr_o,
    output logic                            vmrf_wen_o,
    output logic                            store_data_valid_o,
    output logic                            store_load_index_valid_o,
    output logic       [VL_W-1:0]           vl_o,
    output logic       [ADDR_W-1:0]         start_waddr_o,
    output logic       [ADDR_W-1:0]         start_raddr0_o,
    output logic       [ADDR_W-1:0]         start_raddr1_o,
    output logic       [ADDR_W-1:0]         start_raddr2_o
);

    localparam int LEN_W   = DLY_W + 1;             // L up to MAX_VL_PER_LANE
    localparam int CNT_W   = DLY_W + 2;             // Delay plus L
    localparam int LANE_SH = $clog2(VLANE_NUM);

    typedef enum logic [1:0] {IDLE, START, READ, WRITE} state_e;

    state_e                     state_q;
    state_e                     state_d;
    logic [CNT_W-1:0]           cnt_q;              // Cycle within the phase
    logic [DLY_W-1:0]           vmrf_cnt_q;
    lane_ctrl_pkg::inst_type_e  inst_type_q;
    lane_ctrl_pkg::elem_width_e vsew_q;
    lane_ctrl_pkg::write_sew_e  wsew_q;
    logic [LEN_W-1:0]           len_q;              // Element groups per lane
    logic [DLY_W-1:0]           delay_q;
    logic                       mask_q;
    logic                       accept;
    logic                       read_last;
    logic                       write_last;
    logic                       is_store;

    //////////////////////////////
    // Instruction capture
    //////////////////////////////
    assign accept = ready_o && start_i;

    always_ff @(posedge clk_i) begin
        if (accept) begin
            inst_type_q    <= inst_type_i;
            vsew_q         <= vsew_i;
            wsew_q         <= vrf_write_sew_i;
            delay_q        <= inst_delay_i;
            mask_q         <= vector_mask_i;
            vl_o           <= vl_i;
            // ceil(vl / VLANE_NUM)
            len_q          <= LEN_W'(vl_i >> LANE_SH) + LEN_W'(|vl_i[LANE_SH-1:0]);
            start_waddr_o  <= vrf_starting_waddr_i;
            start_raddr0_o <= vrf_starting_raddr0_i;
            start_raddr1_o <= vrf_starting_raddr1_i;
            start_raddr2_o <= vrf_starting_raddr2_i;
        end
    end

    //////////////////////////////
    // FSM and counters
    //////////////////////////////
    assign read_last  = (cnt_q == CNT_W'(len_q) - CNT_W'(1));
    assign write_last = (cnt_q == CNT_W'(delay_q) + CNT_W'(len_q) - CNT_W'(1));

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (accept) begin
                    state_d = START;
                end
            end
            START: begin
                state_d = READ;     // Counters and tracker load here
            end
            READ: begin
                if (read_last) begin
                    state_d = (inst_type_q == lane_ctrl_pkg::NORMAL) ? WRITE : IDLE;
                end
            end
            WRITE: begin
                if (write_last) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q    <= IDLE;
            cnt_q      <= '0;
            vmrf_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_d != state_q) begin
                cnt_q <= '0;        // Each phase counts from zero
            end else if (state_q == READ || state_q == WRITE) begin
                cnt_q <= cnt_q + CNT_W'(1);
            end
            if (state_q == START) begin
                vmrf_cnt_q <= '0;
            end else if (waddr_en_o) begin
                vmrf_cnt_q <= vmrf_cnt_q + DLY_W'(1);
            end
        end
    end

    //////////////////////////////
    // Phase outputs
    //////////////////////////////
    assign ready_o     = (state_q == IDLE);
    assign addr_load_o = (state_q == START);
    assign vl_load_o   = (state_q == START);
    assign raddr_en_o  = (state_q == READ);
    assign vl_shift_o  = raddr_en_o;
    // Write phase waits inst_delay cycles after the read phase
    assign waddr_en_o  = (state_q == WRITE) && (cnt_q >= CNT_W'(delay_q));
    assign bwen_en_o   = waddr_en_o;

    assign is_store   = (inst_type_q == lane_ctrl_pkg::STORE);
    assign rd_width_o = is_store ? lane_ctrl_pkg::EW_WORD : vsew_q;  // Stores move whole words
    assign wr_width_o = lane_ctrl_pkg::sew_to_width(wsew_q);

    assign vmrf_addr_o = vmrf_cnt_q;
    assign vmrf_wen_o  = waddr_en_o && mask_q;

    assign store_data_valid_o = raddr_en_o
        && (is_store || inst_type_q == lane_ctrl_pkg::INDEXED_STORE);
    assign store_load_index_valid_o = raddr_en_o
        && (inst_type_q == lane_ctrl_pkg::INDEXED_STORE
            || inst_type_q == lane_ctrl_pkg::INDEXED_LOAD);

    // Only the four streamed types run here, and an empty vector would never finish
    a_accept_supported: assert property (
        @(posedge clk_i) disable iff (!rst_i)
        accept |-> (inst_type_i inside {lane_ctrl_pkg::NORMAL, lane_ctrl_pkg::STORE,
                                        lane_ctrl_pkg::INDEXED_STORE,
                                        lane_ctrl_pkg::INDEXED_LOAD})
                   && (vl_i != '0)
    ) else $error("sublane_sequencer: unsupported instruction accepted");

endmodule

`default_nettype wire

/* logic/lane_valid_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module lane_valid_tracker #(
    parameter int  VLANE_NUM       = 8,
    parameter int  MAX_VL_PER_LANE = 256,
    localparam int VL_W            = $clog2(VLANE_NUM * MAX_VL_PER_LANE)
) (
    input  wire                  clk_i,
    input  wire                  rst_i,
    input  wire                  load_i,
    input  wire  [VL_W-1:0]      vl_i,
    input  wire                  shift_i,
    output logic [VLANE_NUM-1:0] valid_o
);

    logic [VL_W-1:0] remain_q;  // Elements not yet read

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            remain_q <= '0;
        end else if (load_i) begin
            remain_q <= vl_i;
        end else if (shift_i) begin
            if (remain_q > VL_W'(VLANE_NUM)) begin
                remain_q <= remain_q - VL_W'(VLANE_NUM);
            end else begin
                remain_q <= '0;     // Last group
            end
        end
    end

    // Thermometer of the remaining count
    always_comb begin
        for (int j = 0; j < VLANE_NUM; j++) begin
            valid_o[j] = shift_i && (VL_W'(j) < remain_q);
        end
    end

    a_shift_with_data: assert property (
        @(posedge clk_i) disable iff (!rst_i)
        shift_i |-> (remain_q != '0)
    ) else $error("lane_valid_tracker: read group past the vector length");

endmodule

`default_nettype wire

/* logic/byte_write_enable_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module byte_write_enable_gen #(
    parameter int  VLANE_NUM = 8,
    localparam int BW        = lane_ctrl_pkg::BYTES_PER_WORD
) (
    input  wire                             clk_i,
    input  wire                             rst_i,
    input  wire                             en_i,
    input  wire lane_ctrl_pkg::elem_width_e width_i,
    output logic       [VLANE_NUM*BW-1:0]   bwen_o
);

    logic [BW-1:0] shift4_q;    // One-hot byte pointer
    logic [1:0]    shift2_q;    // Halfword pointer
    logic [BW-1:0] pattern;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            shift4_q <= BW'(1);
            shift2_q <= 2'b01;
        end else if (en_i) begin
            shift4_q <= {shift4_q[BW-2:0], shift4_q[BW-1]};
            shift2_q <= {shift2_q[0], shift2_q[1]};
        end else begin
            // Next write starts at byte 0 again
            shift4_q <= BW'(1);
            shift2_q <= 2'b01;
        end
    end

    always_comb begin
        case (width_i)
            lane_ctrl_pkg::EW_BYTE: pattern = shift4_q;
            lane_ctrl_pkg::EW_HALF: pattern = {{2{shift2_q[1]}}, {2{shift2_q[0]}}};
            lane_ctrl_pkg::EW_WORD: pattern = '1;
            default:                pattern = '0;
        endcase
    end

    // Every lane writes the same bytes
    assign bwen_o = en_i ? {VLANE_NUM{pattern}} : '0;

endmodule

`default_nettype wire

/* logic/vrf_addr_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module vrf_addr_counter #(
    parameter int  MEM_DEPTH = 512,
    localparam int ADDR_W    = $clog2(MEM_DEPTH)
) (
    input  wire                             clk_i,
    input  wire                             rst_i,
    input  wire                             load_i,
    input  wire        [ADDR_W-1:0]         start_addr_i,
    input  wire                             en_i,
    input  wire lane_ctrl_pkg::elem_width_e width_i,
    output logic       [ADDR_W-1:0]         addr_o
);

    logic [1:0] elem_q;     // Element slot inside the current word

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            elem_q <= '0;
            addr_o <= '0;
        end else if (load_i) begin
            elem_q <= '0;
            addr_o <= start_addr_i;
        end else if (en_i) begin
            if (elem_q == lane_ctrl_pkg::last_elem(width_i)) begin
                elem_q <= '0;
                addr_o <= addr_o + ADDR_W'(1);  // Word used up
            end else begin
                elem_q <= elem_q + 2'd1;
            end
        end
    end

    // Load happens in the start cycle, counting only in a phase
    a_no_load_while_counting: assert property (
        @(posedge clk_i) disable iff (!rst_i)
        !(load_i && en_i)
    ) else $error("vrf_addr_counter: load and count requested together");

endmodule

`default_nettype wire

/* logic/lane_ctrl_pkg.sv */
`default_nettype none

package lane_ctrl_pkg;

    // Instruction types as the issue stage encodes them
    typedef enum logic [2:0] {
        NORMAL        = 3'd0,
        REDUCTION     = 3'd1,
        STORE         = 3'd2,
        INDEXED_STORE = 3'd3,
        LOAD          = 3'd4,
        INDEXED_LOAD  = 3'd5,
        SLIDE         = 3'd6
    } inst_type_e;

    // Element width seen by the address counters and enable generator
    typedef enum logic [1:0] {
        EW_BYTE = 2'd0,
        EW_HALF = 2'd1,
        EW_WORD = 2'd2
    } elem_width_e;

    // Write width as it arrives on the port, code 0 unused
    typedef enum logic [1:0] {
        WS_BYTE = 2'd1,
        WS_HALF = 2'd2,
        WS_WORD = 2'd3
    } write_sew_e;

    localparam int BYTES_PER_WORD = 4;      // Byte enables per lane

    function automatic elem_width_e sew_to_width(input write_sew_e sew);
        case (sew)
            WS_BYTE: return EW_BYTE;
            WS_HALF: return EW_HALF;
            default: return EW_WORD;
        endcase
    endfunction

    // Position of the last element inside one 32-bit word
    function automatic logic [1:0] last_elem(input elem_width_e width);
        case (width)
            EW_BYTE: return 2'd3;
            EW_HALF: return 2'd1;
            default: return 2'd0;
        endcase
    endfunction

endpackage

`default_nettype wire
